// ==== list.f ====
design/emu_cfg_pkg.sv
design/emu_types_pkg.sv
design/emu_ifs.sv
design/pattern_ram.sv
design/pattern_decode.sv
design/injection_exec.sv
design/stats_result.sv
design/traffic_emulator.sv
tb/traffic_emulator_sva.sv
tb/traffic_emulator_tb.sv

// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --binary --timing --assert --timescale 1ns/1ps
TOP       = traffic_emulator_tb
FILELIST  = list.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = Simulation completed successfully

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tb/traffic_emulator_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module traffic_emulator_tb;
    import emu_cfg_pkg::*;
    import emu_types_pkg::*;

    localparam logic [COORD_W-1:0] NODE_X = 4'd1;
    localparam logic [COORD_W-1:0] NODE_Y = 4'd1;
    localparam int DONE_TIMEOUT = 5000;   // cycles

    logic                 clk;
    logic                 reset;
    logic                 host_we_i;
    logic [ADDR_W-1:0]    host_addr_i;
    logic [DATA_W-1:0]    host_wdata_i;
    logic [DATA_W-1:0]    host_rdata_o;
    logic                 start_i;
    logic                 inj_valid_o;
    logic [COORD_W-1:0]   inj_dest_x_o;
    logic [COORD_W-1:0]   inj_dest_y_o;
    logic [CLASS_W-1:0]   inj_class_o;
    logic [PCK_SIZ_W-1:0] inj_size_o;
    logic                 dlv_valid_i;
    logic [LAT_W-1:0]     dlv_latency_i;
    logic                 done_o;

    integer               seed;
    int unsigned          rpt;           // extra passes of the walk
    pattern_fields_t      pat_list[$];   // patterns from address 1 up
    pattern_fields_t      inj_q[$];      // injections seen on the ports

    traffic_emulator #(
        .node_x (NODE_X),
        .node_y (NODE_Y)
    ) dut0 (
        .clk           (clk),
        .reset         (reset),
        .host_we_i     (host_we_i),
        .host_addr_i   (host_addr_i),
        .host_wdata_i  (host_wdata_i),
        .host_rdata_o  (host_rdata_o),
        .start_i       (start_i),
        .inj_valid_o   (inj_valid_o),
        .inj_dest_x_o  (inj_dest_x_o),
        .inj_dest_y_o  (inj_dest_y_o),
        .inj_class_o   (inj_class_o),
        .inj_size_o    (inj_size_o),
        .dlv_valid_i   (dlv_valid_i),
        .dlv_latency_i (dlv_latency_i),
        .done_o        (done_o)
    );

    bind traffic_emulator traffic_emulator_sva sva0 (
        .clk         (clk),
        .reset       (reset),
        .start_i     (start_i),
        .inj_valid_o (inj_valid_o),
        .done_o      (done_o)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("Simulation failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_stat(input string name, input logic [STAT_W-1:0] exp,
                              input logic [STAT_W-1:0] act);
        if (act !== exp) begin
            stop_on_error($sformatf("ERR %s expected %0d actual %0d", name, exp, act));
        end
    endtask

    task automatic check_word(input string name, input pattern_word_t exp,
                              input pattern_word_t act);
        if (act !== exp) begin
            stop_on_error($sformatf("ERR %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            stop_on_error($sformatf("ERR %s expected %b actual %b", name, exp, act));
        end
    endtask

    task automatic check_inj(input string name, input pattern_fields_t exp,
                             input pattern_fields_t act);
        if (act.dest_x !== exp.dest_x || act.dest_y !== exp.dest_y ||
            act.pck_class !== exp.pck_class || act.pck_size !== exp.pck_size) begin
            stop_on_error($sformatf(
                "ERR %s expected x%0d y%0d c%0d s%0d actual x%0d y%0d c%0d s%0d",
                name, exp.dest_x, exp.dest_y, exp.pck_class, exp.pck_size,
                act.dest_x, act.dest_y, act.pck_class, act.pck_size));
        end
    endtask

    function automatic int rand_count(input int max);
        return 1 + int'(($random(seed) & 32'h7fff_ffff) % max);
    endfunction

    // a pattern injects unless empty, zero ratio or aimed at this node
    function automatic bit pattern_active(input pattern_fields_t p);
        return (p.pck_num != '0) && (p.ratio != '0) &&
               !((p.dest_x == NODE_X) && (p.dest_y == NODE_Y));
    endfunction

    function automatic pattern_fields_t make_pattern(input int num, input int ratio,
            input int dx, input int dy, input int cls, input int size);
        pattern_fields_t p;
        p           = '0;
        p.pck_num   = PCK_CNT_W'(num);
        p.ratio     = RATIO_W'(ratio);
        p.dest_x    = COORD_W'(dx);
        p.dest_y    = COORD_W'(dy);
        p.pck_class = CLASS_W'(cls);
        p.pck_size  = PCK_SIZ_W'(size);
        return p;
    endfunction

    task automatic apply_reset();
        reset = 1'b1;
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;
        inj_q.delete();
    endtask

    task automatic host_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
        host_we_i    = 1'b1;
        host_addr_i  = addr;
        host_wdata_i = data;
        @(posedge clk);
        #1;
        host_we_i = 1'b0;
    endtask

    task automatic host_read(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data);
        host_addr_i = addr;
        @(posedge clk);
        #1;
        data = host_rdata_o;   // one cycle read latency
    endtask

    task automatic pulse_start();
        start_i = 1'b1;
        @(posedge clk);
        #1;
        start_i = 1'b0;
    endtask

    task automatic wait_done();
        int n;
        n = 0;
        while (done_o !== 1'b1 && n < DONE_TIMEOUT) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (done_o !== 1'b1) begin
            stop_on_error("timeout: done_o did not rise after start_i");
        end
    endtask

    // samples mid cycle where the strobe is stable
    task automatic inj_watch();
        pattern_fields_t rec;
        forever begin
            @(negedge clk);
            if (inj_valid_o === 1'b1) begin
                rec           = '0;
                rec.dest_x    = inj_dest_x_o;
                rec.dest_y    = inj_dest_y_o;
                rec.pck_class = inj_class_o;
                rec.pck_size  = inj_size_o;
                inj_q.push_back(rec);
            end
        end
    endtask

    initial inj_watch();

    task automatic load_patterns();
        pattern_word_t w;
        w                = '0;
        w.rpt.repeat_cnt = REPEAT_W'(rpt);
        host_write(REPEAT_ADDR, w);
        foreach (pat_list[i]) begin
            w.fields      = pat_list[i];
            w.fields.last = (i == pat_list.size() - 1);
            host_write(PATTERN_FIRST_ADDR + ADDR_W'(i), w);
        end
    endtask

    task automatic run_walk(input string name);
        pattern_fields_t   exp_q[$];
        int unsigned       pass;
        int                k;
        logic [DATA_W-1:0] rd;
        load_patterns();
        for (pass = 0; pass <= rpt; pass++) begin
            foreach (pat_list[i]) begin
                if (pattern_active(pat_list[i])) begin
                    for (k = 0; k < int'(pat_list[i].pck_num); k++) begin
                        exp_q.push_back(pat_list[i]);
                    end
                end
            end
        end
        pulse_start();
        wait_done();
        check_stat({name, " count"}, STAT_W'(exp_q.size()), STAT_W'(inj_q.size()));
        foreach (exp_q[i]) begin
            check_inj($sformatf("%s inj %0d", name, i), exp_q[i], inj_q[i]);
        end
        host_read(SENT_ADDR, rd);
        check_stat({name, " sent"}, STAT_W'(exp_q.size()), rd);
    endtask

    task automatic test_reset_host();
        logic [DATA_W-1:0] wr;
        logic [DATA_W-1:0] rd;
        apply_reset();
        check_flag("reset inj_valid", 1'b0, inj_valid_o);
        check_flag("reset done", 1'b0, done_o);
        wr = {$random(seed), $random(seed)};
        host_write(ADDR_W'(40), wr);
        host_read(ADDR_W'(40), rd);
        check_word("host rw", wr, rd);
    endtask

    task automatic test_single();
        apply_reset();
        pat_list.delete();
        rpt = 0;
        pat_list.push_back(make_pattern(rand_count(20), 100, 3, 2, 5, 48));
        run_walk("single");
    endtask

    task automatic test_skip_inactive();
        apply_reset();
        pat_list.delete();
        rpt = 0;
        pat_list.push_back(make_pattern(5, 100, 1, 1, 1, 8));   // own node
        pat_list.push_back(make_pattern(rand_count(10), 100, 2, 0, 1, 16));
        pat_list.push_back(make_pattern(7, 0, 0, 2, 3, 8));     // zero ratio
        pat_list.push_back(make_pattern(rand_count(10), 100, 3, 3, 2, 32));
        run_walk("skip");
    endtask

    task automatic test_repeat();
        apply_reset();
        pat_list.delete();
        rpt = 2;
        pat_list.push_back(make_pattern(rand_count(8), 50, 0, 0, 3, 12));
        pat_list.push_back(make_pattern(rand_count(8), 100, 2, 2, 4, 20));
        run_walk("repeat");
    endtask

    task automatic test_delivery();
        logic [STAT_W-1:0] exp_recv;
        logic [STAT_W-1:0] exp_lat;
        logic [DATA_W-1:0] rd;
        logic [LAT_W-1:0]  lat;
        int                n;
        apply_reset();
        pat_list.delete();
        rpt = 0;
        pat_list.push_back(make_pattern(4, 10, 0, 3, 1, 24));   // walk of about 40 cycles
        load_patterns();
        pulse_start();
        exp_recv = '0;
        exp_lat  = '0;
        for (n = 0; n < 12; n++) begin
            lat           = LAT_W'(rand_count(1000));
            dlv_valid_i   = 1'b1;
            dlv_latency_i = lat;
            exp_recv      = exp_recv + STAT_W'(1);
            exp_lat       = exp_lat + STAT_W'(lat);
            @(posedge clk);
            #1;
        end
        dlv_valid_i = 1'b0;
        wait_done();
        for (n = 0; n < 5; n++) begin
            dlv_valid_i   = 1'b1;   // late strobes land on frozen stats
            dlv_latency_i = LAT_W'(rand_count(1000));
            @(posedge clk);
            #1;
        end
        dlv_valid_i = 1'b0;
        host_read(RECV_ADDR, rd);
        check_stat("delivery recv", exp_recv, rd);
        host_read(LATENCY_ADDR, rd);
        check_stat("delivery latency", exp_lat, rd);
    endtask

    initial begin
        seed          = 41284;
        rpt           = 0;
        reset         = 1'b1;
        host_we_i     = 1'b0;
        host_addr_i   = '0;
        host_wdata_i  = '0;
        start_i       = 1'b0;
        dlv_valid_i   = 1'b0;
        dlv_latency_i = '0;
        test_reset_host();
        test_single();
        test_skip_inactive();
        test_repeat();
        test_delivery();
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb/traffic_emulator_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

module traffic_emulator_sva (
    input logic clk,
    input logic reset,
    input logic start_i,
    input logic inj_valid_o,
    input logic done_o
);
    logic started_q;   // a start seen since reset

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            started_q <= 1'b0;
        end else if (start_i) begin
            started_q <= 1'b1;
        end
    end

    a_quiet_when_done: assert property (@(posedge clk) disable iff (reset)
        done_o |-> !inj_valid_o)
        else $error("inj_valid_o high while done_o is set");

    a_done_sticky: assert property (@(posedge clk) disable iff (reset)
        done_o |=> done_o)
        else $error("done_o fell without reset");

    a_no_early_inj: assert property (@(posedge clk) disable iff (reset)
        inj_valid_o |-> started_q)
        else $error("injection seen before any start_i");

endmodule

`default_nettype wire

// ==== design/traffic_emulator.sv ====
`timescale 1ns/1ps
`default_nettype none

module traffic_emulator #(
    parameter logic [emu_cfg_pkg::COORD_W-1:0] node_x = 4'd0,
    parameter logic [emu_cfg_pkg::COORD_W-1:0] node_y = 4'd0
) (
    input  logic                               clk,
    input  logic                               reset,
    // host access
    input  logic                               host_we_i,
    input  logic [emu_cfg_pkg::ADDR_W-1:0]     host_addr_i,
    input  logic [emu_cfg_pkg::DATA_W-1:0]     host_wdata_i,
    output logic [emu_cfg_pkg::DATA_W-1:0]     host_rdata_o,
    input  logic                               start_i,
    // injection side
    output logic                               inj_valid_o,
    output logic [emu_cfg_pkg::COORD_W-1:0]    inj_dest_x_o,
    output logic [emu_cfg_pkg::COORD_W-1:0]    inj_dest_y_o,
    output logic [emu_cfg_pkg::CLASS_W-1:0]    inj_class_o,
    output logic [emu_cfg_pkg::PCK_SIZ_W-1:0]  inj_size_o,
    // delivery side
    input  logic                               dlv_valid_i,
    input  logic [emu_cfg_pkg::LAT_W-1:0]      dlv_latency_i,
    output logic                               done_o
);
    import emu_cfg_pkg::*;
    import emu_types_pkg::*;

    logic [ADDR_W-1:0] ram_a_addr;
    pattern_word_t     ram_a_q;
    logic [DATA_W-1:0] ram_b_q;

    pattern_if pat_bus ();
    stats_if   st_bus ();

    pattern_ram u_ram (
        .clk_i     (clk),
        .a_addr_i  (ram_a_addr),
        .a_q_o     (ram_a_q),
        .b_we_i    (host_we_i),
        .b_addr_i  (host_addr_i),
        .b_wdata_i (host_wdata_i),
        .b_q_o     (ram_b_q)
    );

    pattern_decode #(
        .node_x (node_x),
        .node_y (node_y)
    ) u_decode (
        .word_i (ram_a_q),
        .pat    (pat_bus)
    );

    injection_exec u_exec (
        .clk          (clk),
        .reset        (reset),
        .start_i      (start_i),
        .pat          (pat_bus),
        .st           (st_bus),
        .ram_addr_o   (ram_a_addr),
        .inj_valid_o  (inj_valid_o),
        .inj_dest_x_o (inj_dest_x_o),
        .inj_dest_y_o (inj_dest_y_o),
        .inj_class_o  (inj_class_o),
        .inj_size_o   (inj_size_o)
    );

    stats_result u_result (
        .clk           (clk),
        .reset         (reset),
        .st            (st_bus),
        .dlv_valid_i   (dlv_valid_i),
        .dlv_latency_i (dlv_latency_i),
        .host_addr_i   (host_addr_i),
        .ram_q_i       (ram_b_q),
        .host_rdata_o  (host_rdata_o),
        .done_o        (done_o)
    );

endmodule

`default_nettype wire

// ==== design/stats_result.sv ====
`timescale 1ns/1ps
`default_nettype none

module stats_result (
    input  logic                              clk,
    input  logic                              reset,
    stats_if.res                              st,
    input  logic                              dlv_valid_i,
    input  logic [emu_cfg_pkg::LAT_W-1:0]     dlv_latency_i,
    input  logic [emu_cfg_pkg::ADDR_W-1:0]    host_addr_i,
    input  logic [emu_cfg_pkg::DATA_W-1:0]    ram_q_i,
    output logic [emu_cfg_pkg::DATA_W-1:0]    host_rdata_o,
    output logic                              done_o
);
    import emu_cfg_pkg::*;

    logic [STAT_W-1:0] sent_total;
    logic [STAT_W-1:0] recv_total;
    logic [STAT_W-1:0] lat_total;
    logic [ADDR_W-1:0] addr_q;   // aligned with RAM read latency
    logic              dlv_take;

    // counters only move during the walk, so they freeze at finish
    assign dlv_take = st.running && dlv_valid_i;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            sent_total <= '0;
            recv_total <= '0;
            lat_total  <= '0;
        end else begin
            if (st.running && st.sent) begin
                sent_total <= sent_total + STAT_W'(1);
            end
            if (dlv_take) begin
                recv_total <= recv_total + STAT_W'(1);
                lat_total  <= lat_total + STAT_W'(dlv_latency_i);
            end
        end
    end

    // sticky until reset
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            done_o <= 1'b0;
        end else if (st.finish) begin
            done_o <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        addr_q <= host_addr_i;
    end

    // stats overlay the top three addresses
    always_comb begin
        case (addr_q)
            SENT_ADDR:    host_rdata_o = DATA_W'(sent_total);
            RECV_ADDR:    host_rdata_o = DATA_W'(recv_total);
            LATENCY_ADDR: host_rdata_o = DATA_W'(lat_total);
            default:      host_rdata_o = ram_q_i;
        endcase
    end

endmodule

`default_nettype wire

// ==== design/injection_exec.sv ====
`timescale 1ns/1ps
`default_nettype none

module injection_exec (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                start_i,
    pattern_if.exe                              pat,
    stats_if.exe                                st,
    output logic [emu_cfg_pkg::ADDR_W-1:0]      ram_addr_o,
    output logic                                inj_valid_o,
    output logic [emu_cfg_pkg::COORD_W-1:0]     inj_dest_x_o,
    output logic [emu_cfg_pkg::COORD_W-1:0]     inj_dest_y_o,
    output logic [emu_cfg_pkg::CLASS_W-1:0]     inj_class_o,
    output logic [emu_cfg_pkg::PCK_SIZ_W-1:0]   inj_size_o
);
    import emu_cfg_pkg::*;
    import emu_types_pkg::*;

    localparam int ACC_W = RATIO_W + 1;   // acc stays below 100, sum below 200

    exec_state_t          state;
    logic [ADDR_W-1:0]    addr;
    logic [REPEAT_W-1:0]  pass_left;      // passes still to run after this one
    logic [PCK_CNT_W-1:0] sent_cnt;       // packets sent in current pattern
    logic [ACC_W-1:0]     acc;
    logic [RATIO_W-1:0]   ratio_eff;
    logic [ACC_W-1:0]     acc_sum;
    logic [PCK_CNT_W-1:0] sent_nxt;
    logic                 inject;
    logic                 pat_end;
    logic                 at_last;

    // ratios above 100 behave as 100
    assign ratio_eff = (pat.fields.ratio > RATIO_FULL) ? RATIO_FULL : pat.fields.ratio;
    assign acc_sum   = acc + ACC_W'(ratio_eff);
    assign inject    = (state == S_SEND) && pat.active && (acc_sum >= ACC_W'(RATIO_FULL));
    assign sent_nxt  = sent_cnt + PCK_CNT_W'(1);
    assign pat_end   = (state == S_SEND) &&
                       (!pat.active || (inject && (sent_nxt == pat.fields.pck_num)));
    assign at_last   = pat.fields.last || (addr == ADDR_W'(MAX_PATTERN));   // never run into stats

    assign ram_addr_o   = addr;
    assign inj_valid_o  = inject;
    assign inj_dest_x_o = pat.fields.dest_x;
    assign inj_dest_y_o = pat.fields.dest_y;
    assign inj_class_o  = pat.fields.pck_class;
    assign inj_size_o   = pat.fields.pck_size;

    assign st.sent    = inject;
    assign st.running = (state == S_FETCH) || (state == S_SEND);
    assign st.finish  = pat_end && at_last && (pass_left == '0);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state     <= S_IDLE;
            addr      <= REPEAT_ADDR;
            pass_left <= '0;
            sent_cnt  <= '0;
            acc       <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (start_i) begin
                        pass_left <= pat.repeat_cnt;   // RAM is parked on REPEAT_ADDR
                        addr      <= PATTERN_FIRST_ADDR;
                        state     <= S_FETCH;
                    end
                end
                S_FETCH: begin
                    sent_cnt <= '0;   // RAM output settles this cycle
                    acc      <= '0;
                    state    <= S_SEND;
                end
                S_SEND: begin
                    if (pat_end) begin
                        state <= S_FETCH;
                        if (!at_last) begin
                            addr <= addr + ADDR_W'(1);
                        end else if (pass_left == '0) begin
                            state <= S_DONE;
                        end else begin
                            pass_left <= pass_left - REPEAT_W'(1);
                            addr      <= PATTERN_FIRST_ADDR;   // next pass
                        end
                    end else if (inject) begin
                        sent_cnt <= sent_nxt;
                        acc      <= acc_sum - ACC_W'(RATIO_FULL);
                    end else begin
                        acc <= acc_sum;
                    end
                end
                default: begin
                    state <= S_DONE;   // stays here until reset
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== design/pattern_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module pattern_decode #(
    parameter logic [emu_cfg_pkg::COORD_W-1:0] node_x = 4'd0,
    parameter logic [emu_cfg_pkg::COORD_W-1:0] node_y = 4'd0
) (
    input  emu_types_pkg::pattern_word_t word_i,
    pattern_if.dec                       pat
);
    import emu_types_pkg::*;

    pattern_fields_t f;
    logic            self_dest;
    logic            has_pck;
    logic            has_ratio;

    // pattern view of the word
    assign f = word_i.fields;

    // traffic to ourselves never enters the network
    assign self_dest = (f.dest_x == node_x) && (f.dest_y == node_y);
    assign has_pck   = (f.pck_num != '0);
    assign has_ratio = (f.ratio != '0);

    assign pat.fields     = f;
    assign pat.repeat_cnt = word_i.rpt.repeat_cnt;   // repeat view, only meaningful at addr 0
    assign pat.active     = has_pck && has_ratio && !self_dest;

endmodule

`default_nettype wire

// ==== design/pattern_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module pattern_ram (
    input  logic                               clk_i,
    // port a, sequencer side
    input  logic [emu_cfg_pkg::ADDR_W-1:0]     a_addr_i,
    output emu_types_pkg::pattern_word_t       a_q_o,
    // port b, host side
    input  logic                               b_we_i,
    input  logic [emu_cfg_pkg::ADDR_W-1:0]     b_addr_i,
    input  logic [emu_cfg_pkg::DATA_W-1:0]     b_wdata_i,
    output logic [emu_cfg_pkg::DATA_W-1:0]     b_q_o
);
    import emu_cfg_pkg::*;

    localparam int DEPTH = 1 << ADDR_W;

    logic [DATA_W-1:0] mem [0:DEPTH-1];

    // read-only port, one cycle latency
    always_ff @(posedge clk_i) begin
        a_q_o <= mem[a_addr_i];
    end

    // host port, old data on read during write
    always_ff @(posedge clk_i) begin
        if (b_we_i) begin
            mem[b_addr_i] <= b_wdata_i;
        end
        b_q_o <= mem[b_addr_i];
    end

endmodule

`default_nettype wire

// ==== design/emu_ifs.sv ====
`timescale 1ns/1ps
`default_nettype none

// decoded pattern word, decode -> execute
interface pattern_if;
    import emu_cfg_pkg::*;
    import emu_types_pkg::*;

    logic [REPEAT_W-1:0] repeat_cnt;   // valid while the RAM shows address 0
    pattern_fields_t     fields;
    logic                active;       // pattern will inject at all

    modport dec (
        output repeat_cnt,
        output fields,
        output active
    );

    modport exe (
        input repeat_cnt,
        input fields,
        input active
    );
endinterface

// execute -> result event lines
interface stats_if;
    logic sent;      // one packet injected
    logic running;   // walk in progress
    logic finish;    // last pattern of last pass done

    modport exe (
        output sent,
        output running,
        output finish
    );

    modport res (
        input sent,
        input running,
        input finish
    );
endinterface

`default_nettype wire

// ==== design/emu_types_pkg.sv ====
`default_nettype none

package emu_types_pkg;

    // one injection pattern, msb first
    typedef struct packed {
        logic [emu_cfg_pkg::PCK_CNT_W-1:0] pck_num;    // packets to inject
        logic [emu_cfg_pkg::RATIO_W-1:0]   ratio;      // injection ratio in percent
        logic [emu_cfg_pkg::PCK_SIZ_W-1:0] pck_size;   // flits per packet
        logic [emu_cfg_pkg::COORD_W-1:0]   dest_x;
        logic [emu_cfg_pkg::COORD_W-1:0]   dest_y;
        logic [emu_cfg_pkg::CLASS_W-1:0]   pck_class;
        logic                              last;       // final pattern of the list
    } pattern_fields_t;

    // word at REPEAT_ADDR
    typedef struct packed {
        logic [emu_cfg_pkg::DATA_W-emu_cfg_pkg::REPEAT_W-1:0] unused;
        logic [emu_cfg_pkg::REPEAT_W-1:0]                     repeat_cnt;  // extra passes
    } repeat_word_t;

    // the same RAM word, decoded by address
    typedef union packed {
        pattern_fields_t fields;   // addresses 1..124
        repeat_word_t    rpt;      // address 0
    } pattern_word_t;

    typedef enum logic [1:0] {
        S_IDLE,
        S_FETCH,
        S_SEND,
        S_DONE
    } exec_state_t;

endpackage

`default_nettype wire

// ==== design/emu_cfg_pkg.sv ====
`default_nettype none

package emu_cfg_pkg;

    // word and field widths
    localparam int DATA_W    = 64;      // host and RAM word
    localparam int PCK_CNT_W = 30;      // up to 1G packets per pattern
    localparam int RATIO_W   = 7;       // percent, fits 100
    localparam int PCK_SIZ_W = 14;      // 16K flit max
    localparam int COORD_W   = 4;       // 16x16 node grid
    localparam int CLASS_W   = 4;       // message classes
    localparam int REPEAT_W  = 32;      // pass counter in the repeat word
    localparam int LAT_W     = 32;      // delivery latency input
    localparam int STAT_W    = 64;      // statistics counters

    // injection ratio that means every cycle
    localparam logic [RATIO_W-1:0] RATIO_FULL = 7'd100;

    // pattern space and address map
    localparam int MAX_PATTERN = 124;
    localparam int ADDR_W      = 7;     // 124 patterns + repeat + 3 stats

    localparam logic [ADDR_W-1:0] REPEAT_ADDR        = 7'd0;
    localparam logic [ADDR_W-1:0] PATTERN_FIRST_ADDR = 7'd1;
    localparam logic [ADDR_W-1:0] SENT_ADDR          = 7'd125;
    localparam logic [ADDR_W-1:0] RECV_ADDR          = 7'd126;
    localparam logic [ADDR_W-1:0] LATENCY_ADDR       = 7'd127;

endpackage

`default_nettype wire
